//--- spinn_pkt_pkg.sv
package spinn_pkt_pkg;

  // --------------------------------------------------
  // packet geometry
  // --------------------------------------------------
  localparam int PKT_BITS    = 72;   // header, key and optional payload
  localparam int SHORT_SHIFT = 32;   // payload bits absent in a short packet

  typedef logic [PKT_BITS-1:0] pkt_t;      // assembled packet word
  typedef logic [3:0]          nibble_t;   // one data flit worth of bits
  typedef logic [4:0]          flt_cnt_t;  // flits seen in current packet

  // data flits before the eop
  localparam flt_cnt_t SPKT_FLTS = 5'd10;  // short packet, 40 bits
  localparam flt_cnt_t LPKT_FLTS = 5'd18;  // long packet, 72 bits

  // --------------------------------------------------
  // flit from acceptor to deserializer
  // --------------------------------------------------
  // kind bits are one-hot and last a single cycle
  typedef struct packed {
    logic    dat;     // good data nibble
    logic    bad;     // bad symbol taken as a flit
    logic    eop;     // end of packet
    nibble_t nibble;  // decoded value, only meaningful with dat
  } flit_t;

  // deserializer FSM
  typedef enum logic [1:0] {
    DES_IDLE,   // between packets
    DES_TRAN,   // packet coming in
    DES_WAIT    // eop seen but output still holds previous packet
  } des_state_t;

endpackage

//--- spinn_link_pkg.sv
package spinn_link_pkg;

  import spinn_pkt_pkg::*;   // nibble_t for the decoded value

  // --------------------------------------------------
  // 2-of-7 symbol coding
  // --------------------------------------------------
  localparam int SYM_BITS = 7;   // one wire per bit

  typedef logic [SYM_BITS-1:0] sym_t;   // raw nrz or rtz symbol

  localparam sym_t EOP_CODE = 7'b1100000;   // wires 6 and 5

  // data codes indexed by nibble value
  localparam sym_t DATA_CODES [16] = '{
    7'b0010001,   // 0
    7'b0010010,   // 1
    7'b0010100,   // 2
    7'b0011000,   // 3
    7'b0100001,   // 4
    7'b0100010,   // 5
    7'b0100100,   // 6
    7'b0101000,   // 7
    7'b1000001,   // 8
    7'b1000010,   // 9
    7'b1000100,   // 10
    7'b1001000,   // 11
    7'b0000011,   // 12
    7'b0000110,   // 13
    7'b0001100,   // 14
    7'b0001001    // 15
  };

  // --------------------------------------------------
  // classified symbol, detector to acceptor
  // --------------------------------------------------
  typedef struct packed {
    logic    is_dat;   // one of the 16 data codes
    logic    is_eop;   // end-of-packet code
    logic    is_err;   // two or more wires changed, not a legal code
    nibble_t nibble;   // decoded data, zero when not is_dat
    sym_t    raw;      // rtz symbol as seen
  } sym_class_t;

  // acceptor FSM
  typedef enum logic [1:0] {
    ACC_START,   // one ack on reset exit, like the chip does
    ACC_IDLE,    // taking symbols
    ACC_EOPW     // single dead cycle after an eop
  } acc_state_t;

endpackage

//--- symbol_detector.sv
`timescale 1ns/1ps

module symbol_detector
  import spinn_link_pkg::*, spinn_pkt_pkg::*;
(
  input  logic       CLK_IN,
  input  logic       RESET_IN,
  input  sym_t       sl_data_2of7,   // nrz wires straight from the link
  input  logic       accept,         // symbol taken, move reference
  output sym_class_t sym,            // classified rtz symbol
  output logic       sym_bad,        // error code held for two cycles
  output logic       gch_err         // two-cycle pulse per glitch
);

  sym_t    sync_1;     // first synchronizer stage
  sym_t    sync_2;     // second stage, safe to use
  sym_t    ref_q;      // nrz value at last accept
  sym_t    rtz;        // wires changed since last accept
  logic    hit_dat;    // rtz matches a data code
  nibble_t nib_dec;    // its index in the code table
  logic    hit_eop;
  logic    multi;      // two or more bits set in rtz
  logic    hit_err;
  logic    err_seen;   // error code seen in the previous cycle
  logic    glitch;     // error lasted just one cycle
  logic    [1:0] gch_sr;   // stretches glitch to two cycles

  // --------------------------------------------------
  // synchronizer and nrz to rtz
  // --------------------------------------------------
  // no reset here, the stages fill while reset is held
  always_ff @(posedge CLK_IN) begin
    sync_1 <= sl_data_2of7;
    sync_2 <= sync_1;
  end

  always_ff @(posedge CLK_IN) begin
    if (accept) begin
      ref_q <= sync_2;   // start of next symbol
    end
  end

  assign rtz = sync_2 ^ ref_q;

  // --------------------------------------------------
  // classification
  // --------------------------------------------------
  always_comb begin
    hit_dat = 1'b0;
    nib_dec = '0;
    for (int i = 0; i < 16; i++) begin
      if (rtz == DATA_CODES[i]) begin
        hit_dat = 1'b1;
        nib_dec = nibble_t'(i);
      end
    end
  end

  assign hit_eop = (rtz == EOP_CODE);
  assign multi   = |(rtz & (rtz - sym_t'(1)));       // clears lowest set bit
  assign hit_err = multi && !hit_dat && !hit_eop;    // single bit is just incomplete

  assign sym = '{
    is_dat: hit_dat,
    is_eop: hit_eop,
    is_err: hit_err,
    nibble: nib_dec,
    raw:    rtz
  };

  // --------------------------------------------------
  // glitch filter
  // --------------------------------------------------
  // an error code must be present on two consecutive cycles
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      err_seen <= 1'b0;
    end else begin
      err_seen <= hit_err && !err_seen;   // rearm after a taken pair
    end
  end

  assign sym_bad = hit_err && err_seen;
  assign glitch  = err_seen && !hit_err;   // gone after one cycle

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      gch_sr <= 2'b00;
    end else begin
      gch_sr <= {gch_sr[0], glitch};
    end
  end

  assign gch_err = |gch_sr;   // high for exactly two cycles

endmodule

//--- flit_input_ctrl.sv
`timescale 1ns/1ps

module flit_input_ctrl
  import spinn_link_pkg::*, spinn_pkt_pkg::*;
(
  input  logic       CLK_IN,
  input  logic       RESET_IN,
  input  sym_class_t sym,       // current classified symbol
  input  logic       sym_bad,   // filtered bad symbol
  input  logic       flt_cts,   // deserializer can take a flit
  output logic       accept,    // reference update strobe to detector
  output logic       sl_ack,    // link ack, toggles once per symbol
  output flit_t      flit       // one-hot flit, one cycle wide
);

  acc_state_t state;
  logic       take;      // symbol taken this cycle
  logic       flt_dat;
  logic       flt_bad;
  logic       flt_eop;
  nibble_t    flt_nib;   // data for the deserializer

  // --------------------------------------------------
  // symbol acceptance
  // --------------------------------------------------
  assign take = (state == ACC_IDLE) && flt_cts &&
                (sym.is_dat || sym.is_eop || sym_bad);

  // start state also loads the reference with the idle wires
  assign accept = (state == ACC_START) || take;

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= ACC_START;
    end else begin
      case (state)
        ACC_START: state <= ACC_IDLE;
        ACC_IDLE: begin
          if (take && sym.is_eop) begin
            state <= ACC_EOPW;   // let flt_cts settle after eop
          end
        end
        default:   state <= ACC_IDLE;
      endcase
    end
  end

  // ack toggles on the edge after acceptance
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      sl_ack <= 1'b0;
    end else if (accept) begin
      sl_ack <= ~sl_ack;
    end
  end

  // --------------------------------------------------
  // flit output
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_dat <= 1'b0;
      flt_bad <= 1'b0;
      flt_eop <= 1'b0;
    end else begin
      flt_dat <= take && sym.is_dat;
      flt_bad <= take && sym_bad;    // is_dat and is_err never overlap
      flt_eop <= take && sym.is_eop;
    end
  end

  always_ff @(posedge CLK_IN) begin
    if (take && sym.is_dat) begin
      flt_nib <= sym.nibble;
    end
  end

  assign flit = '{dat: flt_dat, bad: flt_bad, eop: flt_eop, nibble: flt_nib};

endmodule

//--- pkt_deserializer.sv
`timescale 1ns/1ps

module pkt_deserializer
  import spinn_pkt_pkg::*;
(
  input  logic  CLK_IN,
  input  logic  RESET_IN,
  input  flit_t flit,       // one-hot flit from the acceptor
  input  logic  pkt_rdy,    // sink ready
  output logic  flt_cts,    // acceptor may take symbols
  output pkt_t  pkt_data,
  output logic  pkt_vld,
  output logic  flt_err,    // two-cycle pulse, first bad flit of a packet
  output logic  frm_err     // two-cycle pulse, eop at wrong count
);

  des_state_t state;
  flt_cnt_t   flit_cnt;    // data and bad flits so far
  logic       long_pkt;    // bit 1 of first nibble
  logic       exp_eop;     // count matches packet length
  logic       pkt_bad;     // bad flit seen in this packet
  pkt_t       pkt_buf;     // shift register, newest nibble on top
  logic       pkt_busy;    // output holds a packet not yet taken
  logic       send_pkt;    // a finished packet wants out
  logic       pkt_out;     // and goes to the output register now
  logic [1:0] flt_sr;      // pulse stretchers
  logic [1:0] frm_sr;

  // --------------------------------------------------
  // output handshake
  // --------------------------------------------------
  assign pkt_busy = pkt_vld && !pkt_rdy;

  always_comb begin
    case (state)
      DES_IDLE,
      DES_TRAN: send_pkt = flit.eop;
      DES_WAIT: send_pkt = 1'b1;      // retry until output frees
      default:  send_pkt = 1'b0;
    endcase
  end

  assign pkt_out = send_pkt && !pkt_busy;

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_vld <= 1'b0;
    end else if (!pkt_busy) begin
      pkt_vld <= send_pkt;   // drops after a transfer with nothing new
    end
  end

  // zero packet on any error, short packets moved down to bit 0
  always_ff @(posedge CLK_IN) begin
    if (pkt_out) begin
      if (!exp_eop || pkt_bad) begin
        pkt_data <= '0;
      end else if (long_pkt) begin
        pkt_data <= pkt_buf;
      end else begin
        pkt_data <= pkt_buf >> SHORT_SHIFT;
      end
    end
  end

  // --------------------------------------------------
  // packet assembly
  // --------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    if (flit.dat) begin
      pkt_buf <= {flit.nibble, pkt_buf[PKT_BITS-1:4]};   // first flit ends lowest
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      long_pkt <= 1'b0;
    end else if ((state == DES_IDLE) && flit.dat) begin
      long_pkt <= flit.nibble[1];   // size bit of the header
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_cnt <= '0;
    end else if (flit.dat || flit.bad) begin
      if (flit_cnt != '1) begin
        flit_cnt <= flit_cnt + 1'b1;   // saturate so a runaway never wraps
      end
    end else if (pkt_out) begin
      flit_cnt <= '0;
    end
  end

  assign exp_eop = long_pkt ? (flit_cnt == LPKT_FLTS) : (flit_cnt == SPKT_FLTS);

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_bad <= 1'b0;
    end else if (flit.bad) begin
      pkt_bad <= 1'b1;
    end else if (pkt_out) begin
      pkt_bad <= 1'b0;   // fresh start for next packet
    end
  end

  // --------------------------------------------------
  // flow control and FSM
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_cts <= 1'b0;
    end else begin
      case (state)
        DES_WAIT: begin
          if (!pkt_busy) begin
            flt_cts <= 1'b1;   // held packet leaves this cycle
          end
        end
        default:  flt_cts <= !(flit.eop && pkt_busy);   // stall behind busy output
      endcase
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= DES_IDLE;
    end else begin
      case (state)
        DES_IDLE: begin
          if (flit.dat || flit.bad) begin
            state <= DES_TRAN;
          end else if (flit.eop && pkt_busy) begin
            state <= DES_WAIT;   // empty packet, still has to go out
          end
        end
        DES_TRAN: begin
          if (flit.eop) begin
            state <= pkt_busy ? DES_WAIT : DES_IDLE;
          end
        end
        DES_WAIT: begin
          if (!pkt_busy) begin
            state <= DES_IDLE;
          end
        end
        default:  state <= DES_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // error pulses
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_sr <= 2'b00;
      frm_sr <= 2'b00;
    end else begin
      flt_sr <= {flt_sr[0], flit.bad && !pkt_bad};   // first bad flit only
      frm_sr <= {frm_sr[0], flit.eop && !exp_eop};
    end
  end

  assign flt_err = |flt_sr;
  assign frm_err = |frm_sr;

endmodule

//--- spinn_link_receiver.sv
`timescale 1ns/1ps

module spinn_link_receiver
  import spinn_link_pkg::*, spinn_pkt_pkg::*;
(
  input  logic CLK_IN,
  input  logic RESET_IN,
  input  sym_t sl_data_2of7,   // link side
  output logic sl_ack,
  output pkt_t pkt_data,       // packet side
  output logic pkt_vld,
  input  logic pkt_rdy,
  output logic gch_err,        // error pulses
  output logic flt_err,
  output logic frm_err
);

  sym_class_t sym;       // classified symbol
  logic       sym_bad;
  logic       accept;    // symbol taken
  flit_t      flit;
  logic       flt_cts;   // back-pressure toward the link

  symbol_detector sym_det (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .sl_data_2of7 (sl_data_2of7),
    .accept       (accept),
    .sym          (sym),
    .sym_bad      (sym_bad),
    .gch_err      (gch_err)
  );

  flit_input_ctrl flit_ctl (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sym      (sym),
    .sym_bad  (sym_bad),
    .flt_cts  (flt_cts),
    .accept   (accept),
    .sl_ack   (sl_ack),
    .flit     (flit)
  );

  pkt_deserializer deser (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flit     (flit),
    .pkt_rdy  (pkt_rdy),
    .flt_cts  (flt_cts),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .flt_err  (flt_err),
    .frm_err  (frm_err)
  );

endmodule

//--- tb_spinn_link_receiver.sv
`timescale 1ns/1ps

module tb_spinn_link_receiver
  import spinn_link_pkg::*, spinn_pkt_pkg::*;
();

  localparam int   N_ROWS       = 7;
  localparam int   MAX_NIB      = 18;           // longest packet
  localparam int   ACK_LIMIT    = 80;           // ack wait in cycles covering a full output stall
  localparam int   QUIET_CYCLES = 10;
  localparam int   SEED         = 32697;
  localparam sym_t BAD_CODE     = 7'b1010000;   // two wires but not in the code table

  typedef enum int {INS_NONE, INS_BAD, INS_GLITCH} ins_kind_t;

  // rising edges seen on each error flag
  typedef struct packed {
    logic [3:0] gch;
    logic [3:0] flt;
    logic [3:0] frm;
  } err_cnt_t;

  logic CLK_IN;
  logic RESET_IN;
  sym_t link_nrz;   // nrz level on the seven wires
  logic sl_ack;
  pkt_t pkt_data;
  logic pkt_vld;
  logic pkt_rdy;
  logic gch_err;
  logic flt_err;
  logic frm_err;

  // --------------------------------------------------
  // stimulus table
  // --------------------------------------------------
  string     row_name  [N_ROWS];
  nibble_t   row_nib   [N_ROWS][MAX_NIB];
  int        row_len   [N_ROWS];
  ins_kind_t row_kind  [N_ROWS];
  int        row_ins   [N_ROWS];   // nibble index of the bad symbol or glitch
  int        row_stall [N_ROWS];   // cycles pkt_rdy stays low once valid shows
  pkt_t      row_exp   [N_ROWS];
  err_cnt_t  row_cnt   [N_ROWS];

  int       errors;
  int       checks;
  int       cycle_cnt;
  int       cycle_limit;
  logic     ack_level;   // last ack level seen by the driver
  logic     link_dead;   // set once an ack goes missing
  err_cnt_t seen_cnt;    // flag edges since the last packet
  logic     gch_q;
  logic     flt_q;
  logic     frm_q;
  logic     held;        // sink stalled a valid packet last cycle
  pkt_t     held_data;

  spinn_link_receiver DUT (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .sl_data_2of7 (link_nrz),
    .sl_ack       (sl_ack),
    .pkt_data     (pkt_data),
    .pkt_vld      (pkt_vld),
    .pkt_rdy      (pkt_rdy),
    .gch_err      (gch_err),
    .flt_err      (flt_err),
    .frm_err      (frm_err)
  );

  initial begin
    CLK_IN = 1'b0;
    forever #10 CLK_IN = ~CLK_IN;   // 20 ns period
  end

  // expected packet from the framing rules with the first flit in the lowest nibble
  function automatic pkt_t rule_packet(input int r);
    pkt_t v;
    int   need;
    v    = '0;
    need = row_nib[r][0][1] ? int'(LPKT_FLTS) : int'(SPKT_FLTS);
    if ((row_kind[r] != INS_BAD) && (row_len[r] == need)) begin
      for (int i = 0; i < row_len[r]; i++) begin
        v[4*i +: 4] = row_nib[r][i];   // short packet leaves zeros above bit 39
      end
    end
    return v;
  endfunction

  function automatic int row_budget(input int r);
    int syms;
    syms = row_len[r] + 1 + ((row_kind[r] == INS_GLITCH) ? 1 : 0);   // plus eop and glitch
    return syms * 20 + row_stall[r] + 50;
  endfunction

  task automatic set_row(input int r, input string name, input int len, input logic is_long,
                         input ins_kind_t kind, input int ins, input int stall,
                         input int gch, input int flt, input int frm);
    row_name[r]  = name;
    row_len[r]   = len;
    row_kind[r]  = kind;
    row_ins[r]   = ins;
    row_stall[r] = stall;
    row_cnt[r]   = '{gch: 4'(gch), flt: 4'(flt), frm: 4'(frm)};
    for (int i = 0; i < MAX_NIB; i++) begin
      row_nib[r][i] = nibble_t'($urandom);
    end
    row_nib[r][0][1] = is_long;   // size bit of the header nibble
    row_exp[r] = rule_packet(r);
  endtask

  task automatic build_table();
    int limit;
    set_row(0, "short",        10, 1'b0, INS_NONE,   -1, 0, 0, 0, 0);
    set_row(1, "long",         18, 1'b1, INS_NONE,   -1, 0, 0, 0, 0);
    set_row(2, "frame_7",       7, 1'b0, INS_NONE,   -1, 0, 0, 0, 1);
    set_row(3, "bad_mid",      10, 1'b0, INS_BAD,     4, 0, 0, 1, 0);
    set_row(4, "glitch",       10, 1'b0, INS_GLITCH,  3, 0, 1, 0, 0);
    set_row(5, "stall_first",  10, 1'b0, INS_NONE,   -1, 5 + int'($urandom % 26), 0, 0, 0);
    set_row(6, "stall_second", 18, 1'b1, INS_NONE,   -1, 0, 0, 0, 0);   // right behind
    limit = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      limit += row_budget(r);
    end
    cycle_limit = limit;
  endtask

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic compare_pkt(input string name, input pkt_t exp_p, input pkt_t act_p);
    checks++;
    if (act_p !== exp_p) begin
      $display("Mismatch %s packet: expected %h actual %h", name, exp_p, act_p);
      errors++;
    end
  endtask

  task automatic compare_cnt(input string name, input err_cnt_t exp_c, input err_cnt_t act_c);
    checks++;
    if (act_c.gch !== exp_c.gch) begin
      $display("Mismatch %s gch_err pulses: expected %0d actual %0d", name, exp_c.gch, act_c.gch);
      errors++;
    end
    if (act_c.flt !== exp_c.flt) begin
      $display("Mismatch %s flt_err pulses: expected %0d actual %0d", name, exp_c.flt, act_c.flt);
      errors++;
    end
    if (act_c.frm !== exp_c.frm) begin
      $display("Mismatch %s frm_err pulses: expected %0d actual %0d", name, exp_c.frm, act_c.frm);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // link driver
  // --------------------------------------------------
  task automatic wait_ack(input string name);
    int waited;
    waited = 0;
    if (!link_dead) begin
      while ((sl_ack == ack_level) && (waited < ACK_LIMIT)) begin
        @(negedge CLK_IN);
        waited++;
      end
      if (sl_ack == ack_level) begin
        $display("receiver never toggled the ack in test %s", name);
        errors++;
        link_dead = 1'b1;   // protocol is stuck so stop driving
      end else begin
        ack_level = sl_ack;
      end
    end
  endtask

  task automatic send_symbol(input sym_t code, input string name);
    if (!link_dead) begin
      @(posedge CLK_IN);
      link_nrz <= link_nrz ^ code;   // flip both wires of the code at once
      wait_ack(name);
    end
  endtask

  task automatic send_glitch(input string name);
    if (!link_dead) begin
      @(posedge CLK_IN);
      link_nrz <= link_nrz ^ BAD_CODE;
      @(posedge CLK_IN);
      link_nrz <= link_nrz ^ BAD_CODE;   // back after one cycle
      repeat (3) @(posedge CLK_IN);
      @(negedge CLK_IN);
      if (sl_ack != ack_level) begin
        $display("receiver acknowledged a one-cycle glitch in test %s", name);
        errors++;
        ack_level = sl_ack;   // keep the driver in step with the ack
      end
    end
  endtask

  task automatic drive_link();
    wait_ack("start");   // start toggle out of reset
    for (int r = 0; r < N_ROWS; r++) begin
      for (int i = 0; i < row_len[r]; i++) begin
        if ((i == row_ins[r]) && (row_kind[r] == INS_GLITCH)) begin
          send_glitch(row_name[r]);
        end
        if ((i == row_ins[r]) && (row_kind[r] == INS_BAD)) begin
          send_symbol(BAD_CODE, row_name[r]);   // takes the nibble's place
        end else begin
          send_symbol(DATA_CODES[row_nib[r][i]], row_name[r]);
        end
      end
      send_symbol(EOP_CODE, row_name[r]);
    end
  endtask

  // --------------------------------------------------
  // packet monitor
  // --------------------------------------------------
  // one sample per cycle at the falling edge with flags before the hold check
  task automatic sample_cycle(input string name);
    @(negedge CLK_IN);
    if (gch_err && !gch_q) begin
      seen_cnt.gch = seen_cnt.gch + 4'd1;
    end
    if (flt_err && !flt_q) begin
      seen_cnt.flt = seen_cnt.flt + 4'd1;
    end
    if (frm_err && !frm_q) begin
      seen_cnt.frm = seen_cnt.frm + 4'd1;
    end
    gch_q = gch_err;
    flt_q = flt_err;
    frm_q = frm_err;
    if (held) begin
      if (!pkt_vld) begin
        $display("pkt_vld dropped in test %s while the sink was not ready", name);
        errors++;
      end
      compare_pkt({name, "_hold"}, held_data, pkt_data);   // data must not move
    end
    held      = pkt_vld && !pkt_rdy;
    held_data = pkt_data;
  endtask

  task automatic watch_packets();
    int waited;
    int stalled;
    bit got;
    for (int r = 0; r < N_ROWS; r++) begin
      waited  = 0;
      stalled = 0;
      got     = 1'b0;
      if (row_stall[r] > 0) begin
        @(posedge CLK_IN);
        pkt_rdy <= 1'b0;   // sink busy before the packet shows up
      end
      while (!got && (waited < row_budget(r))) begin
        sample_cycle(row_name[r]);
        waited++;
        if (pkt_vld && pkt_rdy) begin
          got = 1'b1;   // transfer this cycle
        end else if (pkt_vld && (stalled < row_stall[r])) begin
          stalled++;
          if (stalled == row_stall[r]) begin
            @(posedge CLK_IN);
            pkt_rdy <= 1'b1;
          end
        end
      end
      if (got) begin
        compare_pkt(row_name[r], row_exp[r], pkt_data);
        compare_cnt(row_name[r], row_cnt[r], seen_cnt);
      end else begin
        $display("no packet arrived for test %s", row_name[r]);
        errors++;
      end
      seen_cnt = '0;
    end
  endtask

  task automatic check_quiet();
    bit extra;
    extra = 1'b0;
    repeat (QUIET_CYCLES) begin
      sample_cycle("trailing");
      if (pkt_vld) begin
        extra = 1'b1;
      end
    end
    if (extra) begin
      $display("an extra packet appeared after the last test");
      errors++;
    end
    compare_cnt("trailing", '0, seen_cnt);
  endtask

  // --------------------------------------------------
  // run control
  // --------------------------------------------------
  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK_IN);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without finishing", cycle_cnt);
    $display("checks: %0d  errors: %0d", checks, errors + 1);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    RESET_IN  = 1'b1;
    link_nrz  = '0;
    pkt_rdy   = 1'b1;
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    ack_level = 1'b0;
    link_dead = 1'b0;
    seen_cnt  = '0;
    gch_q     = 1'b0;
    flt_q     = 1'b0;
    frm_q     = 1'b0;
    held      = 1'b0;
    held_data = '0;
    void'($urandom(SEED));
    build_table();
    repeat (2) @(posedge CLK_IN);
    RESET_IN <= 1'b0;
    fork
      drive_link();
      watch_packets();
    join
    check_quiet();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
spinn_pkt_pkg.sv
spinn_link_pkg.sv
symbol_detector.sv
flit_input_ctrl.sv
pkt_deserializer.sv
spinn_link_receiver.sv
tb_spinn_link_receiver.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_spinn_link_receiver
LOG=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module "$TOP" -o "sim_$TOP"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"sim_$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
